//--- files.f
+incdir+hw
+incdir+sim
hw/rv_core_pkg.sv
hw/rv_hazard_if.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_hazard_unit.sv
hw/rv_word_ram.sv
hw/rv_pipe_core.sv
sim/tb_rv_pipe_core.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_rv_pipe_core
FILELIST  = files.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// table size, one row per scenario
localparam int NUM_ROWS  = 6;
localparam int MAX_WORDS = 16;
localparam int MAX_RET   = 16;

// rv32i opcodes and funct3 values
localparam int OPC_IMM  = 'h13;
localparam int OPC_LOAD = 'h03;
localparam int F_ADD    = 0;
localparam int F_SLT    = 2;
localparam int F_XOR    = 4;
localparam int F_OR     = 6;
localparam int F_AND    = 7;
localparam int F_LW     = 2;
localparam int F_BEQ    = 0;
localparam int F_BNE    = 1;
localparam int F7_SUB   = 'h20;

string       row_name    [NUM_ROWS];
logic [31:0] prog_words  [NUM_ROWS][MAX_WORDS];
int          prog_len    [NUM_ROWS];
logic [4:0]  exp_rd      [NUM_ROWS][MAX_RET];
logic [31:0] exp_data    [NUM_ROWS][MAX_RET];
int          exp_count   [NUM_ROWS];
// retirements seen before reset is pulsed, zero for none
int          reset_after [NUM_ROWS];

//////////////////////////////
// instruction encoders
//////////////////////////////

function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(int opc, int imm, int rs1, int f3, int rd);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
endfunction

// sw only, word funct3
function automatic logic [31:0] enc_s(int imm, int rs2, int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_b(int imm, int rs2, int rs1, int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_j(int imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
endfunction

function automatic logic [31:0] enc_lui(int upper, int rd);
    return {upper[19:0], rd[4:0], 7'b0110111};
endfunction

// instruction that leaves nothing on the retirement stream
task automatic add_instr(int r, logic [31:0] w);
    prog_words[r][prog_len[r]] = w;
    prog_len[r]++;
endtask

// instruction plus its expected retirement, in program order
task automatic add_retiring(int r, logic [31:0] w, int rd, logic [31:0] d);
    add_instr(r, w);
    exp_rd[r][exp_count[r]]   = rd[4:0];
    exp_data[r][exp_count[r]] = d;
    exp_count[r]++;
endtask

task automatic build_table();
    int r;
    for (r = 0; r < NUM_ROWS; r++)
    begin
        prog_len[r]    = 0;
        exp_count[r]   = 0;
        reset_after[r] = 0;
    end
    // dependent alu chain, both forwarding paths
    row_name[0] = "alu chain";
    add_retiring(0, enc_i(OPC_IMM, 5, 0, F_ADD, 1), 1, 32'h0000_0005);
    add_retiring(0, enc_i(OPC_IMM, -3, 1, F_ADD, 2), 2, 32'h0000_0002);
    add_retiring(0, enc_r(F7_SUB, 2, 1, F_ADD, 3), 3, 32'h0000_0003);
    add_retiring(0, enc_i(OPC_IMM, -7, 0, F_ADD, 5), 5, 32'hffff_fff9);
    add_retiring(0, enc_r(0, 1, 5, F_SLT, 6), 6, 32'h0000_0001);
    add_retiring(0, enc_i(OPC_IMM, -8, 5, F_SLT, 7), 7, 32'h0000_0000);
    add_retiring(0, enc_lui('h12345, 8), 8, 32'h1234_5000);
    add_retiring(0, enc_i(OPC_IMM, 'h0f0, 8, F_OR, 9), 9, 32'h1234_50f0);
    add_retiring(0, enc_r(0, 3, 9, F_XOR, 10), 10, 32'h1234_50f3);
    add_retiring(0, enc_i(OPC_IMM, 'h0ff, 10, F_AND, 11), 11, 32'h0000_00f3);
    add_retiring(0, enc_r(0, 6, 11, F_ADD, 12), 12, 32'h0000_00f4);
    add_retiring(0, enc_i(OPC_IMM, -1, 12, F_XOR, 13), 13, 32'hffff_ff0b);
    add_retiring(0, enc_r(0, 9, 13, F_AND, 14), 14, 32'h1234_5000);
    add_retiring(0, enc_r(0, 12, 14, F_OR, 15), 15, 32'h1234_50f4);
    // store, load, then an immediate use of the load
    row_name[1] = "load use";
    add_retiring(1, enc_i(OPC_IMM, 'h7a, 0, F_ADD, 1), 1, 32'h0000_007a);
    add_retiring(1, enc_i(OPC_IMM, 16, 0, F_ADD, 2), 2, 32'h0000_0010);
    add_instr(1, enc_s(4, 1, 2));
    add_retiring(1, enc_i(OPC_LOAD, 4, 2, F_LW, 3), 3, 32'h0000_007a);
    add_retiring(1, enc_r(0, 1, 3, F_ADD, 4), 4, 32'h0000_00f4);
    add_retiring(1, enc_i(OPC_IMM, 1, 4, F_ADD, 5), 5, 32'h0000_00f5);
    // beq at pc 8 lands on word 5, bne there falls through
    row_name[2] = "branches";
    add_retiring(2, enc_i(OPC_IMM, 3, 0, F_ADD, 1), 1, 32'h0000_0003);
    add_retiring(2, enc_i(OPC_IMM, 3, 0, F_ADD, 2), 2, 32'h0000_0003);
    add_instr(2, enc_b(12, 2, 1, F_BEQ));
    add_instr(2, enc_i(OPC_IMM, 'h11, 0, F_ADD, 3));
    add_instr(2, enc_i(OPC_IMM, 'h22, 0, F_ADD, 4));
    add_instr(2, enc_b(8, 2, 1, F_BNE));
    add_retiring(2, enc_i(OPC_IMM, 'h33, 0, F_ADD, 5), 5, 32'h0000_0033);
    add_retiring(2, enc_i(OPC_IMM, 1, 5, F_ADD, 6), 6, 32'h0000_0034);
    // jal at pc 4, link is 8, target word 4
    row_name[3] = "jal";
    add_retiring(3, enc_i(OPC_IMM, 1, 0, F_ADD, 1), 1, 32'h0000_0001);
    add_retiring(3, enc_j(12, 5), 5, 32'h0000_0008);
    add_instr(3, enc_i(OPC_IMM, 'h55, 0, F_ADD, 2));
    add_instr(3, enc_i(OPC_IMM, 'h66, 0, F_ADD, 3));
    add_retiring(3, enc_r(0, 1, 5, F_ADD, 4), 4, 32'h0000_0009);
    // x0 as a destination and as a source
    row_name[4] = "x0 writes";
    add_instr(4, enc_i(OPC_IMM, 'h44, 0, F_ADD, 0));
    add_retiring(4, enc_i(OPC_IMM, 'h21, 0, F_ADD, 1), 1, 32'h0000_0021);
    add_instr(4, enc_r(0, 1, 1, F_ADD, 0));
    add_retiring(4, enc_r(0, 1, 0, F_ADD, 2), 2, 32'h0000_0021);
    add_instr(4, enc_lui('habcde, 0));
    add_retiring(4, enc_r(0, 0, 1, F_ADD, 3), 3, 32'h0000_0021);
    // reset pulsed after two retirements, then the whole run again
    row_name[5]    = "reset midway";
    reset_after[5] = 2;
    add_retiring(5, enc_i(OPC_IMM, 10, 0, F_ADD, 1), 1, 32'd10);
    add_retiring(5, enc_i(OPC_IMM, 20, 1, F_ADD, 2), 2, 32'd30);
    add_retiring(5, enc_i(OPC_IMM, 30, 2, F_ADD, 3), 3, 32'd60);
    add_retiring(5, enc_r(0, 1, 3, F_ADD, 4), 4, 32'd70);
    add_retiring(5, enc_r(F7_SUB, 2, 4, F_ADD, 5), 5, 32'd40);
endtask

`endif

//--- sim/tb_rv_pipe_core.sv
`timescale 1ns/100ps

module tb_rv_pipe_core;

    localparam int IMEM_WORDS     = 64;
    localparam int TIMEOUT_CYCLES = 200;
    localparam int QUIET_CYCLES   = 8;

    logic        clk;
    logic        rst_n;
    logic        i_imem_we;
    logic [5:0]  i_imem_addr;
    logic [31:0] i_imem_data;
    logic        o_wb_valid;
    logic [4:0]  o_wb_rd;
    logic [31:0] o_wb_data;

    int total_errors;
    int row_errors;
    int rows_passed;
    int rows_failed;

    `include "tb_programs.svh"

    rv_pipe_core rv_pipe_core_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_imem_we   (i_imem_we),
        .i_imem_addr (i_imem_addr),
        .i_imem_data (i_imem_data),
        .o_wb_valid  (o_wb_valid),
        .o_wb_rd     (o_wb_rd),
        .o_wb_data   (o_wb_data)
    );

    // 8 ns period
    initial clk = 1'b0;
    always #4 clk = ~clk;

    //////////////////////////////
    // helpers
    //////////////////////////////

    // inputs change and outputs are read 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // opcode zero decodes to a bubble, upper bits carry the address
    function automatic logic [31:0] pad_word(int w);
        return {19'h0, 6'(w), 7'h00};
    endfunction

    // core held in reset while imem is written
    task automatic load_program(int r);
        int w;
        rst_n = 1'b0;
        repeat (2) next_cycle();
        for (w = 0; w < IMEM_WORDS; w++)
        begin
            i_imem_we   = 1'b1;
            i_imem_addr = 6'(w);
            if (w < prog_len[r])
                i_imem_data = prog_words[r][w];
            else
                i_imem_data = pad_word(w);
            next_cycle();
        end
        i_imem_we   = 1'b0;
        i_imem_addr = '0;
        i_imem_data = '0;
    endtask

    task automatic check_retirement(int r, int k);
        if (o_wb_rd !== exp_rd[r][k])
        begin
            $display("Fail row %0d retirement %0d o_wb_rd got 0x%0h expected 0x%0h",
                     r, k, o_wb_rd, exp_rd[r][k]);
            row_errors++;
        end
        if (o_wb_data !== exp_data[r][k])
        begin
            $display("Fail row %0d retirement %0d o_wb_data got 0x%0h expected 0x%0h",
                     r, k, o_wb_data, exp_data[r][k]);
            row_errors++;
        end
    endtask

    // idle counter restarts on every retirement
    task automatic collect_retirements(int r, int count);
        int seen;
        int idle;
        seen = 0;
        idle = 0;
        while (seen < count && idle < TIMEOUT_CYCLES)
        begin
            next_cycle();
            if (o_wb_valid)
            begin
                check_retirement(r, seen);
                seen++;
                idle = 0;
            end
            else
                idle++;
        end
        if (seen < count)
        begin
            $display("row %0d timed out after %0d of %0d retirements", r, seen, count);
            row_errors++;
        end
    endtask

    // flushed or x0 instructions must stay off the stream
    task automatic check_no_extra(int r);
        int c;
        for (c = 0; c < QUIET_CYCLES; c++)
        begin
            next_cycle();
            if (o_wb_valid)
            begin
                $display("row %0d retired an unexpected write to x%0d", r, o_wb_rd);
                row_errors++;
            end
        end
    endtask

    task automatic pulse_reset(int r);
        rst_n = 1'b0;
        repeat (2)
        begin
            next_cycle();
            if (o_wb_valid !== 1'b0)
            begin
                $display("Fail row %0d o_wb_valid got 0x%0h expected 0x0 in reset",
                         r, o_wb_valid);
                row_errors++;
            end
        end
        rst_n = 1'b1;
    endtask

    //////////////////////////////
    // table loop
    //////////////////////////////

    initial
    begin
        int r;
        rst_n        = 1'b0;
        i_imem_we    = 1'b0;
        i_imem_addr  = '0;
        i_imem_data  = '0;
        total_errors = 0;
        rows_passed  = 0;
        rows_failed  = 0;
        build_table();
        for (r = 0; r < NUM_ROWS; r++)
        begin
            row_errors = 0;
            load_program(r);
            rst_n = 1'b1;
            if (reset_after[r] > 0)
            begin
                collect_retirements(r, reset_after[r]);
                pulse_reset(r);
            end
            collect_retirements(r, exp_count[r]);
            check_no_extra(r);
            if (row_errors == 0)
            begin
                $display("row %0d %s ok", r, row_name[r]);
                rows_passed++;
            end
            else
            begin
                $display("row %0d %s failed with %0d errors", r, row_name[r], row_errors);
                rows_failed++;
            end
            total_errors += row_errors;
        end
        $display("rows passed %0d, rows failed %0d, errors %0d",
                 rows_passed, rows_failed, total_errors);
        if (total_errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

//--- hw/rv_pipe_core.sv
`timescale 1ns/100ps
`include "rv_core_defines.svh"

module rv_pipe_core
    import rv_core_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              i_imem_we,
    input  logic [$clog2(`RV_IMEM_WORDS)-1:0] i_imem_addr,
    input  logic [`RV_XLEN-1:0]               i_imem_data,
    output logic                              o_wb_valid,
    output logic [`RV_REG_AW-1:0]             o_wb_rd,
    output logic [`RV_XLEN-1:0]               o_wb_data
);

    localparam int IMEM_AW = $clog2(`RV_IMEM_WORDS);
    localparam int DMEM_AW = $clog2(`RV_DMEM_WORDS);

    // fetch and if/id
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] pc_next;
    logic [`RV_XLEN-1:0] imem_rdata;
    logic [`RV_XLEN-1:0] ifid_pc;
    logic [`RV_XLEN-1:0] ifid_instr;
    // decode and id/ex
    ctrl_t               id_ctrl;
    logic [`RV_XLEN-1:0] id_imm;
    logic [`RV_XLEN-1:0] id_rs1_data;
    logic [`RV_XLEN-1:0] id_rs2_data;
    ctrl_t               idex_ctrl;
    logic [`RV_XLEN-1:0] idex_pc;
    logic [`RV_XLEN-1:0] idex_imm;
    logic [`RV_XLEN-1:0] idex_rs1_data;
    logic [`RV_XLEN-1:0] idex_rs2_data;
    // execute and ex/mem
    logic [`RV_XLEN-1:0] ex_a;
    logic [`RV_XLEN-1:0] ex_b_reg;
    logic [`RV_XLEN-1:0] ex_alu;
    logic [`RV_XLEN-1:0] ex_target;
    logic [`RV_XLEN-1:0] ex_link;
    logic                ex_zero;
    logic                ex_taken;
    ctrl_t               exmem_ctrl;
    logic [`RV_XLEN-1:0] exmem_link;
    logic [`RV_XLEN-1:0] exmem_alu;
    logic [`RV_XLEN-1:0] exmem_wdata;
    logic [`RV_XLEN-1:0] mem_fwd_data;
    logic [`RV_XLEN-1:0] mem_rdata;
    // mem/wb
    ctrl_t               memwb_ctrl;
    logic [`RV_XLEN-1:0] memwb_link;
    logic [`RV_XLEN-1:0] memwb_alu;
    logic [`RV_XLEN-1:0] memwb_rdata;
    logic [`RV_XLEN-1:0] wb_data;

    rv_hazard_if hz_if (.clk(clk));

    function automatic logic [`RV_XLEN-1:0] fwd_mux(
        input fwd_sel_e            sel,
        input logic [`RV_XLEN-1:0] reg_val,
        input logic [`RV_XLEN-1:0] mem_val,
        input logic [`RV_XLEN-1:0] wb_val
    );
        case (sel)
            FWD_EX_MEM: return mem_val;
            FWD_MEM_WB: return wb_val;
            default:    return reg_val;
        endcase
    endfunction

    //////////////////////////////
    // fetch
    //////////////////////////////

    rv_word_ram #(.WORDS(`RV_IMEM_WORDS)) imem_inst (
        .clk     (clk),
        .i_we    (i_imem_we),
        .i_waddr (i_imem_addr),
        .i_wdata (i_imem_data),
        .i_raddr (pc[IMEM_AW+1:2]),
        .o_rdata (imem_rdata)
    );

    // always not-taken, redirect from execute overrides a stall
    assign pc_next = ex_taken ? ex_target : (hz_if.stall ? pc : pc + 'd4);

    //////////////////////////////
    // decode
    //////////////////////////////

    rv_decoder decoder_inst (
        .i_instr (ifid_instr),
        .o_ctrl  (id_ctrl),
        .o_imm   (id_imm)
    );

    rv_regfile regfile_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_rs1      (id_ctrl.rs1),
        .i_rs2      (id_ctrl.rs2),
        .i_rd       (memwb_ctrl.rd),
        .i_rd_data  (wb_data),
        .i_we       (memwb_ctrl.reg_write),
        .o_rs1_data (id_rs1_data),
        .o_rs2_data (id_rs2_data)
    );

    // hazard inputs from each stage
    assign hz_if.id_rs1        = id_ctrl.rs1;
    assign hz_if.id_rs2        = id_ctrl.rs2;
    assign hz_if.ex_rs1        = idex_ctrl.rs1;
    assign hz_if.ex_rs2        = idex_ctrl.rs2;
    assign hz_if.ex_rd         = idex_ctrl.rd;
    assign hz_if.ex_mem_read   = idex_ctrl.mem_read;
    assign hz_if.mem_rd        = exmem_ctrl.rd;
    assign hz_if.mem_reg_write = exmem_ctrl.reg_write;
    assign hz_if.wb_rd         = memwb_ctrl.rd;
    assign hz_if.wb_reg_write  = memwb_ctrl.reg_write;

    rv_hazard_unit hazard_unit_inst (.hz(hz_if.unit));

    //////////////////////////////
    // execute
    //////////////////////////////

    assign ex_a     = fwd_mux(hz_if.fwd_a, idex_rs1_data, mem_fwd_data, wb_data);
    assign ex_b_reg = fwd_mux(hz_if.fwd_b, idex_rs2_data, mem_fwd_data, wb_data);

    rv_alu alu_inst (
        .i_op     (idex_ctrl.alu_op),
        .i_a      (ex_a),
        .i_b      (idex_ctrl.use_imm ? idex_imm : ex_b_reg),
        .o_result (ex_alu),
        .o_zero   (ex_zero)
    );

    // branch and jal target, link for jal
    assign ex_target = idex_pc + idex_imm;
    assign ex_link   = idex_pc + 'd4;
    assign ex_taken  = (idex_ctrl.br_kind == BR_JAL)
                       || (idex_ctrl.br_kind == BR_BEQ && ex_zero)
                       || (idex_ctrl.br_kind == BR_BNE && !ex_zero);

    //////////////////////////////
    // memory and writeback
    //////////////////////////////

    rv_word_ram #(.WORDS(`RV_DMEM_WORDS)) dmem_inst (
        .clk     (clk),
        .i_we    (exmem_ctrl.mem_write),
        .i_waddr (exmem_alu[DMEM_AW+1:2]),
        .i_wdata (exmem_wdata),
        .i_raddr (exmem_alu[DMEM_AW+1:2]),
        .o_rdata (mem_rdata)
    );

    // loads never forward from ex/mem, the stall keeps them apart
    assign mem_fwd_data = (exmem_ctrl.wb_sel == WB_LINK) ? exmem_link : exmem_alu;

    always_comb
    begin
        case (memwb_ctrl.wb_sel)
            WB_MEM:  wb_data = memwb_rdata;
            WB_LINK: wb_data = memwb_link;
            default: wb_data = memwb_alu;
        endcase
    end

    // retirement stream
    assign o_wb_valid = memwb_ctrl.reg_write;
    assign o_wb_rd    = memwb_ctrl.rd;
    assign o_wb_data  = wb_data;

    //////////////////////////////
    // pipeline registers
    //////////////////////////////

    // control, redirect flushes, stall bubbles id/ex
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            pc         <= '0;
            ifid_instr <= '0;
            idex_ctrl  <= '0;
            exmem_ctrl <= '0;
            memwb_ctrl <= '0;
        end
        else
        begin
            pc <= pc_next;
            if (ex_taken)
            begin
                ifid_instr <= '0;
                idex_ctrl  <= '0;
            end
            else if (hz_if.stall)
                idex_ctrl <= '0;
            else
            begin
                ifid_instr <= imem_rdata;
                idex_ctrl  <= id_ctrl;
            end
            exmem_ctrl <= idex_ctrl;
            memwb_ctrl <= exmem_ctrl;
        end
    end

    // payload follows its control word
    always_ff @(posedge clk)
    begin
        if (!hz_if.stall)
            ifid_pc <= pc;
        idex_pc       <= ifid_pc;
        idex_imm      <= id_imm;
        idex_rs1_data <= id_rs1_data;
        idex_rs2_data <= id_rs2_data;
        exmem_link    <= ex_link;
        exmem_alu     <= ex_alu;
        exmem_wdata   <= ex_b_reg;
        memwb_link    <= exmem_link;
        memwb_alu     <= exmem_alu;
        memwb_rdata   <= mem_rdata;
    end

    // only a load stalls and only a branch or jal redirects, never both at once
    a_stall_or_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        !(hz_if.stall && ex_taken));

    // decode clears reg_write for x0, checked at retirement
    a_wb_rd_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        o_wb_valid |-> (o_wb_rd != '0));

endmodule

//--- hw/rv_word_ram.sv
`timescale 1ns/100ps
`include "rv_core_defines.svh"

module rv_word_ram #(
    parameter int WORDS = 64
) (
    input  logic                     clk,
    input  logic                     i_we,
    input  logic [$clog2(WORDS)-1:0] i_waddr,
    input  logic [`RV_XLEN-1:0]      i_wdata,
    input  logic [$clog2(WORDS)-1:0] i_raddr,
    output logic [`RV_XLEN-1:0]      o_rdata
);

    logic [`RV_XLEN-1:0] mem [WORDS];

    // write on the edge
    always_ff @(posedge clk)
    begin
        if (i_we)
            mem[i_waddr] <= i_wdata;
    end

    // read is combinational
    assign o_rdata = mem[i_raddr];

    a_waddr_in_range: assert property (@(posedge clk)
        i_we |-> (i_waddr < WORDS));

endmodule

//--- hw/rv_hazard_unit.sv
`timescale 1ns/100ps

module rv_hazard_unit
    import rv_core_pkg::*;
(
    rv_hazard_if.unit hz
);

    logic a_from_mem;
    logic a_from_wb;
    logic b_from_mem;
    logic b_from_wb;

    // match against the ex/mem producer
    assign a_from_mem = hz.mem_reg_write && (hz.mem_rd != '0) && (hz.mem_rd == hz.ex_rs1);
    assign b_from_mem = hz.mem_reg_write && (hz.mem_rd != '0) && (hz.mem_rd == hz.ex_rs2);
    // then the mem/wb producer
    assign a_from_wb  = hz.wb_reg_write && (hz.wb_rd != '0) && (hz.wb_rd == hz.ex_rs1);
    assign b_from_wb  = hz.wb_reg_write && (hz.wb_rd != '0) && (hz.wb_rd == hz.ex_rs2);

    // youngest producer wins
    assign hz.fwd_a = a_from_mem ? FWD_EX_MEM : (a_from_wb ? FWD_MEM_WB : FWD_REG);
    assign hz.fwd_b = b_from_mem ? FWD_EX_MEM : (b_from_wb ? FWD_MEM_WB : FWD_REG);

    // load in execute feeding decode, hold one cycle
    assign hz.stall = hz.ex_mem_read && (hz.ex_rd != '0)
                      && ((hz.ex_rd == hz.id_rs1) || (hz.ex_rd == hz.id_rs2));

    // a writing producer in ex/mem never names x0
    a_mem_rd_nonzero: assert property (@(posedge hz.clk)
        hz.mem_reg_write |-> (hz.mem_rd != '0));

endmodule

//--- hw/rv_alu.sv
`timescale 1ns/100ps
`include "rv_core_defines.svh"

module rv_alu
    import rv_core_pkg::*;
(
    input  alu_op_e             i_op,
    input  logic [`RV_XLEN-1:0] i_a,
    input  logic [`RV_XLEN-1:0] i_b,
    output logic [`RV_XLEN-1:0] o_result,
    output logic                o_zero
);

    logic slt;

    // signed compare
    assign slt = $signed(i_a) < $signed(i_b);

    always_comb
    begin
        case (i_op)
            ALU_ADD:    o_result = i_a + i_b;
            ALU_SUB:    o_result = i_a - i_b;
            ALU_AND:    o_result = i_a & i_b;
            ALU_OR:     o_result = i_a | i_b;
            ALU_XOR:    o_result = i_a ^ i_b;
            ALU_SLT:    o_result = {{(`RV_XLEN-1){1'b0}}, slt};
            // lui immediate straight through
            ALU_PASS_B: o_result = i_b;
            default:    o_result = '0;
        endcase
    end

    // beq and bne read this after a sub
    assign o_zero = (o_result == '0);

endmodule

//--- hw/rv_regfile.sv
`timescale 1ns/100ps
`include "rv_core_defines.svh"

module rv_regfile (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`RV_REG_AW-1:0] i_rs1,
    input  logic [`RV_REG_AW-1:0] i_rs2,
    input  logic [`RV_REG_AW-1:0] i_rd,
    input  logic [`RV_XLEN-1:0]   i_rd_data,
    input  logic                  i_we,
    output logic [`RV_XLEN-1:0]   o_rs1_data,
    output logic [`RV_XLEN-1:0]   o_rs2_data
);

    logic [`RV_XLEN-1:0] regs [32];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (i_we)
            regs[i_rd] <= i_rd_data;
    end

    // x0 reads zero, same-cycle write passes through to decode
    assign o_rs1_data = (i_rs1 == '0) ? '0 : (i_we && i_rs1 == i_rd) ? i_rd_data : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : (i_we && i_rs2 == i_rd) ? i_rd_data : regs[i_rs2];

    // decode drops reg_write for rd zero
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        i_we |-> (i_rd != '0));

endmodule

//--- hw/rv_decoder.sv
`timescale 1ns/100ps
`include "rv_core_defines.svh"

module rv_decoder
    import rv_core_pkg::*;
(
    input  logic [`RV_XLEN-1:0] i_instr,
    output ctrl_t               o_ctrl,
    output logic [`RV_XLEN-1:0] o_imm
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_j;
    logic [`RV_XLEN-1:0] imm_u;
    logic                valid;
    logic                use_rs1;
    logic                use_rs2;
    logic                use_rd;
    ctrl_t               ctrl;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    // sign extended immediates
    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};

    always_comb
    begin
        ctrl    = '0;
        o_imm   = '0;
        valid   = 1'b1;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        use_rd  = 1'b0;
        case (opcode)
            `RV_OPC_OP:
            begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                use_rd  = 1'b1;
                case (funct3)
                    `RV_F3_ADD: ctrl.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    `RV_F3_SLT: ctrl.alu_op = ALU_SLT;
                    `RV_F3_XOR: ctrl.alu_op = ALU_XOR;
                    `RV_F3_OR:  ctrl.alu_op = ALU_OR;
                    `RV_F3_AND: ctrl.alu_op = ALU_AND;
                    default:    valid = 1'b0;
                endcase
                // funct7 must be zero, sub is the only exception
                if (funct7 != 7'b0 && !(funct7 == 7'b0100000 && funct3 == `RV_F3_ADD))
                    valid = 1'b0;
            end
            `RV_OPC_OP_IMM:
            begin
                use_rs1      = 1'b1;
                use_rd       = 1'b1;
                ctrl.use_imm = 1'b1;
                o_imm        = imm_i;
                case (funct3)
                    `RV_F3_ADD: ctrl.alu_op = ALU_ADD;
                    `RV_F3_SLT: ctrl.alu_op = ALU_SLT;
                    `RV_F3_XOR: ctrl.alu_op = ALU_XOR;
                    `RV_F3_OR:  ctrl.alu_op = ALU_OR;
                    `RV_F3_AND: ctrl.alu_op = ALU_AND;
                    default:    valid = 1'b0;
                endcase
            end
            `RV_OPC_LOAD:
            begin
                use_rs1       = 1'b1;
                use_rd        = 1'b1;
                ctrl.use_imm  = 1'b1;
                ctrl.mem_read = 1'b1;
                ctrl.wb_sel   = WB_MEM;
                o_imm         = imm_i;
                valid         = (funct3 == `RV_F3_LW);
            end
            `RV_OPC_STORE:
            begin
                use_rs1        = 1'b1;
                use_rs2        = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
                o_imm          = imm_s;
                // sw shares the word funct3 with lw
                valid          = (funct3 == `RV_F3_LW);
            end
            `RV_OPC_BRANCH:
            begin
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
                ctrl.alu_op = ALU_SUB;
                o_imm       = imm_b;
                case (funct3)
                    `RV_F3_BEQ: ctrl.br_kind = BR_BEQ;
                    `RV_F3_BNE: ctrl.br_kind = BR_BNE;
                    default:    valid = 1'b0;
                endcase
            end
            `RV_OPC_JAL:
            begin
                use_rd       = 1'b1;
                ctrl.br_kind = BR_JAL;
                ctrl.wb_sel  = WB_LINK;
                o_imm        = imm_j;
            end
            `RV_OPC_LUI:
            begin
                use_rd       = 1'b1;
                ctrl.use_imm = 1'b1;
                ctrl.alu_op  = ALU_PASS_B;
                o_imm        = imm_u;
            end
            default:
                valid = 1'b0;
        endcase
        // unused register fields stay zero so hazard checks ignore them
        ctrl.rs1       = use_rs1 ? i_instr[19:15] : '0;
        ctrl.rs2       = use_rs2 ? i_instr[24:20] : '0;
        ctrl.rd        = use_rd ? i_instr[11:7] : '0;
        ctrl.reg_write = use_rd && (i_instr[11:7] != '0);
        o_ctrl         = valid ? ctrl : '0;
    end

endmodule

//--- hw/rv_hazard_if.sv
`timescale 1ns/100ps
`include "rv_core_defines.svh"

interface rv_hazard_if
    import rv_core_pkg::*;
(
    input logic clk
);

    // sources of the instruction in decode
    logic [`RV_REG_AW-1:0] id_rs1;
    logic [`RV_REG_AW-1:0] id_rs2;
    // instruction in execute
    logic [`RV_REG_AW-1:0] ex_rs1;
    logic [`RV_REG_AW-1:0] ex_rs2;
    logic [`RV_REG_AW-1:0] ex_rd;
    logic                  ex_mem_read;
    // older producers
    logic [`RV_REG_AW-1:0] mem_rd;
    logic                  mem_reg_write;
    logic [`RV_REG_AW-1:0] wb_rd;
    logic                  wb_reg_write;
    // results back to the pipeline
    fwd_sel_e              fwd_a;
    fwd_sel_e              fwd_b;
    logic                  stall;

    modport pipe (
        output id_rs1, id_rs2, ex_rs1, ex_rs2, ex_rd, ex_mem_read,
        output mem_rd, mem_reg_write, wb_rd, wb_reg_write,
        input  fwd_a, fwd_b, stall
    );

    modport unit (
        input  clk,
        input  id_rs1, id_rs2, ex_rs1, ex_rs2, ex_rd, ex_mem_read,
        input  mem_rd, mem_reg_write, wb_rd, wb_reg_write,
        output fwd_a, fwd_b, stall
    );

endinterface

//--- hw/rv_core_pkg.sv
package rv_core_pkg;

`include "rv_core_defines.svh"

    // alu operations, pass_b feeds lui
    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SLT    = 3'd5,
        ALU_PASS_B = 3'd6
    } alu_op_e;

    // writeback source, link is pc+4
    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_MEM  = 2'd1,
        WB_LINK = 2'd2
    } wb_sel_e;

    // operand source for execute
    typedef enum logic [1:0] {
        FWD_REG    = 2'd0,
        FWD_EX_MEM = 2'd1,
        FWD_MEM_WB = 2'd2
    } fwd_sel_e;

    typedef enum logic [1:0] {
        BR_NONE = 2'd0,
        BR_BEQ  = 2'd1,
        BR_BNE  = 2'd2,
        BR_JAL  = 2'd3
    } br_kind_e;

    // decoded control word, all zero is a bubble
    typedef struct packed {
        logic [`RV_REG_AW-1:0] rs1;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rd;
        alu_op_e               alu_op;
        logic                  use_imm;
        br_kind_e              br_kind;
        logic                  mem_read;
        logic                  mem_write;
        logic                  reg_write;
        wb_sel_e               wb_sel;
    } ctrl_t;

endpackage

//--- hw/rv_core_defines.svh
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// datapath and register address widths
`define RV_XLEN          32
`define RV_REG_AW        5

// memory depths in words
`define RV_IMEM_WORDS    64
`define RV_DMEM_WORDS    64

// opcodes of the supported subset
`define RV_OPC_OP        7'b0110011
`define RV_OPC_OP_IMM    7'b0010011
`define RV_OPC_LOAD      7'b0000011
`define RV_OPC_STORE     7'b0100011
`define RV_OPC_BRANCH    7'b1100011
`define RV_OPC_JAL       7'b1101111
`define RV_OPC_LUI       7'b0110111

// funct3 codes
`define RV_F3_ADD        3'b000
`define RV_F3_SLT        3'b010
`define RV_F3_XOR        3'b100
`define RV_F3_OR         3'b110
`define RV_F3_AND        3'b111
`define RV_F3_BEQ        3'b000
`define RV_F3_BNE        3'b001
`define RV_F3_LW         3'b010

`endif
